//--- Makefile
# Verilator build and run of the usb_tx testbench, invoked from the project root
VERILATOR ?= verilator
TOP       ?= tb_usb_tx
FILELIST  ?= usb_tx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/bit_stuffer.sv
// stuffs a zero after RUN_LEN ones and stalls the source for that cycle
// the source must hold its beat while stall is high
`timescale 1ns/10ps
`default_nettype none

module bit_stuffer #(
  parameter int unsigned RUN_LEN = usb_tx_pkg::STUFF_RUN
) (
  input  logic                 clk,
  input  logic                 rst_L,
  input  usb_tx_pkg::tx_beat_t beat_in,
  output usb_tx_pkg::tx_beat_t beat_out,
  output logic                 stall
);

  localparam int unsigned CNT_W = $clog2(RUN_LEN);

  logic [CNT_W-1:0] ones_cnt;
  logic             stuff_pend;
  logic             pend_last;
  logic             run_done;

  // the one that completes a run is on the input now
  assign run_done = beat_in.valid && beat_in.value &&
                    (ones_cnt == CNT_W'(RUN_LEN - 1));
  assign stall    = stuff_pend;

  always_comb begin
    beat_out = beat_in;
    if (stuff_pend) begin
      beat_out.valid = 1'b1;
      beat_out.value = 1'b0;
      beat_out.last  = pend_last;
    end else begin
      // last moves onto the stuffed zero
      beat_out.last = beat_in.last && !run_done;
    end
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      ones_cnt   <= '0;
      stuff_pend <= 1'b0;
      pend_last  <= 1'b0;
    end else if (stuff_pend) begin
      ones_cnt   <= '0;
      stuff_pend <= 1'b0;
      pend_last  <= 1'b0;
    end else if (!beat_in.valid || !beat_in.value) begin
      ones_cnt <= '0;
    end else if (run_done) begin
      ones_cnt   <= '0;
      stuff_pend <= 1'b1;
      pend_last  <= beat_in.last;
    end else begin
      ones_cnt <= ones_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/crc_gen.sv
// serial CRC, preset to all ones; message bits go in one per shift_in cycle
// the inverted remainder leaves MSB first, one bit per shift_out cycle
`timescale 1ns/10ps
`default_nettype none

module crc_gen #(
  parameter int unsigned      CRC_W = usb_tx_pkg::CRC16_W,
  parameter logic [CRC_W-1:0] POLY  = usb_tx_pkg::CRC16_POLY
) (
  input  logic clk,
  input  logic rst_L,
  input  logic clr,
  input  logic shift_in,
  input  logic shift_out,
  input  logic din,
  output logic dout
);

  logic [CRC_W-1:0] crc_q;
  logic             fb;

  // feedback of the top bit against the incoming message bit
  assign fb   = crc_q[CRC_W-1] ^ din;
  assign dout = ~crc_q[CRC_W-1];

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      crc_q <= '1;
    end else if (clr) begin
      crc_q <= '1;
    end else if (shift_in) begin
      crc_q <= {crc_q[CRC_W-2:0], 1'b0} ^ (fb ? POLY : '0);
    end else if (shift_out) begin
      // fill value is never sent
      crc_q <= {crc_q[CRC_W-2:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

//--- logic/line_driver.sv
// drives dp/dm from line levels, then SE0, SE0, J and a one-cycle eop_done
// the bus rests at J with oe low between packets
`timescale 1ns/10ps
`default_nettype none

module line_driver (
  input  logic                 clk,
  input  logic                 rst_L,
  input  usb_tx_pkg::tx_beat_t beat_in,
  output logic                 dp,
  output logic                 dm,
  output logic                 oe,
  output logic                 eop_done
);

  typedef enum logic [2:0] {IDLE, PACKET, SE0_1, SE0_2, J_END} state_e;

  state_e state;

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state    <= IDLE;
      dp       <= 1'b1;
      dm       <= 1'b0;
      oe       <= 1'b0;
      eop_done <= 1'b0;
    end else begin
      eop_done <= 1'b0;
      case (state)
        IDLE, PACKET: begin
          if (beat_in.valid) begin
            // level 1 is J, level 0 is K
            dp    <= beat_in.value;
            dm    <= ~beat_in.value;
            oe    <= 1'b1;
            state <= beat_in.last ? SE0_1 : PACKET;
          end else begin
            dp    <= 1'b1;
            dm    <= 1'b0;
            oe    <= 1'b0;
            state <= IDLE;
          end
        end
        SE0_1: begin
          dp    <= 1'b0;
          dm    <= 1'b0;
          state <= SE0_2;
        end
        SE0_2: begin
          dp    <= 1'b0;
          dm    <= 1'b0;
          state <= J_END;
        end
        J_END: begin
          // final J of EOP, oe drops on the next cycle
          dp       <= 1'b1;
          dm       <= 1'b0;
          eop_done <= 1'b1;
          state    <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/nrzi_encoder.sv
// NRZI coder, one cycle of latency; a one holds the level, a zero toggles it
`timescale 1ns/10ps
`default_nettype none

module nrzi_encoder (
  input  logic                 clk,
  input  logic                 rst_L,
  input  usb_tx_pkg::tx_beat_t beat_in,
  output usb_tx_pkg::tx_beat_t beat_out
);

  logic level;
  logic next_level;

  assign next_level = beat_in.value ? level : ~level;

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      level    <= 1'b1;
      beat_out <= '0;
    end else begin
      beat_out.valid <= beat_in.valid;
      beat_out.value <= beat_in.valid ? next_level : 1'b1;
      beat_out.last  <= beat_in.valid && beat_in.last;
      if (beat_in.valid) begin
        // back to J once the packet is through
        level <= beat_in.last ? 1'b1 : next_level;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/packet_serializer.sv
// turns one latched packet into SYNC, PID, fields and CRC, one bit per cycle
// unknown PIDs are framed like handshakes; the whole FSM freezes while stall is high
`timescale 1ns/10ps
`default_nettype none

module packet_serializer #(
  parameter int unsigned          TOK_CRC_W = usb_tx_pkg::CRC5_W,
  parameter logic [TOK_CRC_W-1:0] TOK_POLY  = usb_tx_pkg::CRC5_POLY,
  parameter int unsigned          DAT_CRC_W = usb_tx_pkg::CRC16_W,
  parameter logic [DAT_CRC_W-1:0] DAT_POLY  = usb_tx_pkg::CRC16_POLY
) (
  input  logic                 clk,
  input  logic                 rst_L,
  input  logic                 req,
  input  usb_tx_pkg::usb_pkt_t pkt,
  input  logic                 stall,
  input  logic                 eop_done,
  output logic                 ack,
  output usb_tx_pkg::tx_beat_t beat
);
  import usb_tx_pkg::*;

  // bit index within the current field, wide enough for the payload
  localparam int unsigned CNT_W   = $clog2(DATA_W);
  localparam int unsigned PID_IW  = $clog2(PID_W);
  localparam int unsigned ADDR_IW = $clog2(ADDR_W);
  localparam int unsigned ENDP_IW = $clog2(ENDP_W);

  typedef enum logic [3:0] {
    IDLE, SYNC, PID, ADDR, ENDP, DATA, CRC, WAIT_EOP, ACK_HI
  } state_e;

  state_e           state;
  usb_pkt_t         pkt_q;
  logic [CNT_W-1:0] fld_cnt;
  logic [CNT_W-1:0] crc_end;
  logic [PID_W-1:0] pid_bits;
  logic             accept;
  logic             sending;
  logic             is_token;
  logic             is_data;
  logic             cur_bit;
  logic             fld_end;
  logic             pkt_end;
  logic             crc5_in;
  logic             crc5_out;
  logic             crc5_bit;
  logic             crc16_in;
  logic             crc16_out;
  logic             crc16_bit;

  assign accept   = (state == IDLE) && req;
  assign sending  = state inside {SYNC, PID, ADDR, ENDP, DATA, CRC};
  assign pid_bits = pkt_q.pid;
  assign is_token = (pkt_q.pid == OUT) || (pkt_q.pid == IN);
  assign is_data  = (pkt_q.pid == DATA0);
  assign crc_end  = is_token ? CNT_W'(TOK_CRC_W - 1) : CNT_W'(DAT_CRC_W - 1);

  // crc registers advance only together with the stream
  assign crc5_in   = !stall && (state == ADDR || state == ENDP);
  assign crc16_in  = !stall && (state == DATA);
  assign crc5_out  = !stall && (state == CRC) && is_token;
  assign crc16_out = !stall && (state == CRC) && !is_token;

  // handshakes end on the last PID bit, everything else on the last CRC bit
  assign pkt_end = fld_end && ((state == CRC) ||
                   (state == PID && !is_token && !is_data));

  always_comb begin
    cur_bit = 1'b0;
    fld_end = 1'b0;
    case (state)
      SYNC: begin
        // seven zeros, then the closing one
        fld_end = (fld_cnt == CNT_W'(SYNC_W - 1));
        cur_bit = fld_end;
      end
      PID: begin
        cur_bit = pid_bits[fld_cnt[PID_IW-1:0]];
        fld_end = (fld_cnt == CNT_W'(PID_W - 1));
      end
      ADDR: begin
        cur_bit = pkt_q.addr[fld_cnt[ADDR_IW-1:0]];
        fld_end = (fld_cnt == CNT_W'(ADDR_W - 1));
      end
      ENDP: begin
        cur_bit = pkt_q.endp[fld_cnt[ENDP_IW-1:0]];
        fld_end = (fld_cnt == CNT_W'(ENDP_W - 1));
      end
      DATA: begin
        cur_bit = pkt_q.data[fld_cnt];
        fld_end = (fld_cnt == CNT_W'(DATA_W - 1));
      end
      CRC: begin
        cur_bit = is_token ? crc5_bit : crc16_bit;
        fld_end = (fld_cnt == crc_end);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= pkt;
    end
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state   <= IDLE;
      fld_cnt <= '0;
      beat    <= '0;
      ack     <= 1'b0;
    end else if (!stall) begin
      beat.valid <= sending;
      beat.value <= cur_bit;
      beat.last  <= pkt_end;
      fld_cnt    <= (fld_end || !sending) ? '0 : fld_cnt + 1'b1;
      case (state)
        IDLE:     if (req) state <= SYNC;
        SYNC:     if (fld_end) state <= PID;
        PID: begin
          if (fld_end) begin
            if (is_token) state <= ADDR;
            else if (is_data) state <= DATA;
            else state <= WAIT_EOP;
          end
        end
        ADDR:     if (fld_end) state <= ENDP;
        ENDP:     if (fld_end) state <= CRC;
        DATA:     if (fld_end) state <= CRC;
        CRC:      if (fld_end) state <= WAIT_EOP;
        WAIT_EOP: begin
          if (eop_done) begin
            ack   <= 1'b1;
            state <= ACK_HI;
          end
        end
        ACK_HI: begin
          // client drops req before the next packet
          if (!req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default:  state <= IDLE;
      endcase
    end
  end

  crc_gen #(.CRC_W(TOK_CRC_W), .POLY(TOK_POLY)) crc5_i (
    .clk      (clk),
    .rst_L    (rst_L),
    .clr      (accept),
    .shift_in (crc5_in),
    .shift_out(crc5_out),
    .din      (cur_bit),
    .dout     (crc5_bit)
  );

  crc_gen #(.CRC_W(DAT_CRC_W), .POLY(DAT_POLY)) crc16_i (
    .clk      (clk),
    .rst_L    (rst_L),
    .clr      (accept),
    .shift_in (crc16_in),
    .shift_out(crc16_out),
    .din      (cur_bit),
    .dout     (crc16_bit)
  );

endmodule

`default_nettype wire

//--- logic/usb_tx.sv
// USB full-speed host transmit path, one packet per req/ack handshake
// pkt must stay stable while req is high; only OUT, IN, DATA0, ACK and NAK are framed
`timescale 1ns/10ps
`default_nettype none

module usb_tx #(
  parameter int unsigned          TOK_CRC_W = usb_tx_pkg::CRC5_W,
  parameter logic [TOK_CRC_W-1:0] TOK_POLY  = usb_tx_pkg::CRC5_POLY,
  parameter int unsigned          DAT_CRC_W = usb_tx_pkg::CRC16_W,
  parameter logic [DAT_CRC_W-1:0] DAT_POLY  = usb_tx_pkg::CRC16_POLY,
  parameter int unsigned          RUN_LEN   = usb_tx_pkg::STUFF_RUN
) (
  input  logic                 clk,
  input  logic                 rst_L,
  input  logic                 req,
  input  usb_tx_pkg::usb_pkt_t pkt,
  output logic                 ack,
  output logic                 dp,
  output logic                 dm,
  output logic                 oe
);
  import usb_tx_pkg::*;

  tx_beat_t raw_beat;
  tx_beat_t stuffed_beat;
  tx_beat_t line_beat;
  logic     stall;
  logic     eop_done;

  packet_serializer #(
    .TOK_CRC_W(TOK_CRC_W),
    .TOK_POLY (TOK_POLY),
    .DAT_CRC_W(DAT_CRC_W),
    .DAT_POLY (DAT_POLY)
  ) packet_serializer_i (
    .clk     (clk),
    .rst_L   (rst_L),
    .req     (req),
    .pkt     (pkt),
    .stall   (stall),
    .eop_done(eop_done),
    .ack     (ack),
    .beat    (raw_beat)
  );

  bit_stuffer #(.RUN_LEN(RUN_LEN)) bit_stuffer_i (
    .clk     (clk),
    .rst_L   (rst_L),
    .beat_in (raw_beat),
    .beat_out(stuffed_beat),
    .stall   (stall)
  );

  // value leaves the encoder as the line level
  nrzi_encoder nrzi_encoder_i (
    .clk     (clk),
    .rst_L   (rst_L),
    .beat_in (stuffed_beat),
    .beat_out(line_beat)
  );

  line_driver line_driver_i (
    .clk     (clk),
    .rst_L   (rst_L),
    .beat_in (line_beat),
    .dp      (dp),
    .dm      (dm),
    .oe      (oe),
    .eop_done(eop_done)
  );

endmodule

`default_nettype wire

//--- logic/usb_tx_pkg.sv
// shared types and constants of the USB full-speed transmit path
// PID values carry their check nibble, and every field goes out LSB first
`default_nettype none

package usb_tx_pkg;

  // field widths
  localparam int unsigned ADDR_W = 7;
  localparam int unsigned ENDP_W = 4;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned PID_W  = 8;
  localparam int unsigned SYNC_W = 8;

  // token crc, x^5 + x^2 + 1
  localparam int unsigned       CRC5_W    = 5;
  localparam logic [CRC5_W-1:0] CRC5_POLY = 5'b00101;

  // data crc, x^16 + x^15 + x^2 + 1
  localparam int unsigned        CRC16_W    = 16;
  localparam logic [CRC16_W-1:0] CRC16_POLY = 16'h8005;

  // ones in a row before a zero is stuffed
  localparam int unsigned STUFF_RUN = 6;

  // complete PID bytes, check nibble in the upper half
  typedef enum logic [PID_W-1:0] {
    OUT   = 8'hE1,
    IN    = 8'h69,
    DATA0 = 8'hC3,
    ACK   = 8'hD2,
    NAK   = 8'h5A
  } pid_e;

  // one packet request from the client
  typedef struct packed {
    pid_e              pid;
    logic [ADDR_W-1:0] addr;
    logic [ENDP_W-1:0] endp;
    logic [DATA_W-1:0] data;
  } usb_pkt_t;

  // one bit on the serial pipeline
  typedef struct packed {
    logic valid;
    logic value;
    logic last;
  } tx_beat_t;

endpackage

`default_nettype wire

//--- tb/tb_clock_gen.sv
// clock and active-low reset for the testbench
// reset is released on a rising edge after RST_CYCLES cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst_L
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_L = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_L <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_usb_tx.sv
// testbench for usb_tx with packets and expected CRCs taken from tb/usb_tx_stim.txt
// the simulation must be started from the project root so the stim path resolves
`timescale 1ns/10ps
`default_nettype none

module tb_usb_tx;
  import usb_tx_pkg::*;

  localparam string       STIM_FILE   = "tb/usb_tx_stim.txt";
  localparam int          MAX_PKTS    = 32;
  localparam int          COLS        = 5;
  localparam int          TIMEOUT_CYC = 2000;
  localparam logic [31:0] SEED        = 32'h2434_055b;

  logic        clk;
  logic        rst_L;
  logic        req;
  usb_pkt_t    pkt;
  logic        ack;
  logic        dp;
  logic        dm;
  logic        oe;
  logic [63:0] stim_mem [MAX_PKTS*COLS];
  int          num_pkts;
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  logic        timed_out;

  // line monitor state is cleared before each packet
  logic rx_bits[$];
  int   ones_run;
  logic prev_level;
  int   se0_cnt;
  logic eop_seen;

  tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) clock_gen_i (.clk(clk), .rst_L(rst_L));

  usb_tx usb_tx_i (
    .clk  (clk),
    .rst_L(rst_L),
    .req  (req),
    .pkt  (pkt),
    .ack  (ack),
    .dp   (dp),
    .dm   (dm),
    .oe   (oe)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT_CYC, what);
    err_cnt++;
    timed_out = 1'b1;
  endtask

  // ack is sampled on the falling edge where the registered outputs are settled
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    while (ack !== level && cycles < TIMEOUT_CYC) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== level) report_timeout(level ? "ack to rise" : "ack to fall");
  endtask

  task automatic clear_monitor();
    rx_bits.delete();
    ones_run   = 0;
    prev_level = 1'b1;
    se0_cnt    = 0;
    eop_seen   = 1'b0;
  endtask

  // decoded bits from pos onward with the first received bit as LSB
  function automatic logic [63:0] field_value(input int pos, input int width);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < width; i++) v[i] = rx_bits[pos + i];
    return v;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d error(s)", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  task automatic check_packet(input usb_pkt_t sent, input logic [63:0] exp_crc);
    int   n_bits;
    logic is_token;
    logic is_data;
    is_token = (sent.pid == OUT) || (sent.pid == IN);
    is_data  = (sent.pid == DATA0);
    // handshakes carry SYNC and PID only
    n_bits = SYNC_W + PID_W;
    if (is_token) n_bits = n_bits + ADDR_W + ENDP_W + CRC5_W;
    if (is_data) n_bits = n_bits + DATA_W + CRC16_W;
    check_value("bit_count", 64'(rx_bits.size()), 64'(n_bits));
    check_value("eop_seen", 64'(eop_seen), 64'd1);
    check_value("oe", 64'(oe), 64'd0);
    if (rx_bits.size() == n_bits) begin
      check_value("sync", field_value(0, SYNC_W), 64'h80);
      check_value("pid", field_value(8, PID_W), 64'(sent.pid));
      if (is_token) begin
        check_value("addr", field_value(16, ADDR_W), 64'(sent.addr));
        check_value("endp", field_value(23, ENDP_W), 64'(sent.endp));
        check_value("crc5", field_value(27, CRC5_W), exp_crc);
      end
      if (is_data) begin
        check_value("data", field_value(16, DATA_W), sent.data);
        check_value("crc16", field_value(80, CRC16_W), exp_crc);
      end
    end
  endtask

  // NRZI decode and destuff while the DUT drives the line
  always @(negedge clk) begin : line_monitor
    logic bit_val;
    if (rst_L && oe) begin
      check_value("ack", 64'(ack), 64'd0);
      if (!dp && !dm) begin
        se0_cnt++;
      end else if (se0_cnt > 0) begin
        // first state after SE0 closes the EOP
        check_value("se0_cycles", 64'(se0_cnt), 64'd2);
        check_value("eop_level", 64'({dp, dm}), 64'b10);
        eop_seen = 1'b1;
      end else begin
        bit_val    = (dp == prev_level);
        prev_level = dp;
        if (ones_run == STUFF_RUN) begin
          if (bit_val) begin
            $display("stuffing error: seven ones in a row on the line");
            err_cnt++;
          end
          ones_run = 0;
        end else begin
          rx_bits.push_back(bit_val);
          ones_run = bit_val ? ones_run + 1 : 0;
        end
      end
    end
  end

  initial begin : main
    usb_pkt_t next_pkt;
    pid_e     kind;
    int       gap;
    int       cycles;
    int       errs_before;
    req       = 1'b0;
    pkt       = '0;
    err_cnt   = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    clear_monitor();
    void'($urandom(SEED));
    for (int i = 0; i < MAX_PKTS * COLS; i++) stim_mem[i] = '1;
    $readmemh(STIM_FILE, stim_mem);
    num_pkts = 0;
    while (num_pkts < MAX_PKTS && stim_mem[num_pkts*COLS] !== '1) num_pkts++;
    if (num_pkts == 0) begin
      $display("no packets found in %s", STIM_FILE);
      err_cnt++;
    end

    cycles = 0;
    while (rst_L !== 1'b1 && cycles < TIMEOUT_CYC) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_L !== 1'b1) report_timeout("reset release");
    @(negedge clk);
    errs_before = err_cnt;
    check_value("ack", 64'(ack), 64'd0);
    check_value("oe", 64'(oe), 64'd0);
    check_value("dp", 64'(dp), 64'd1);
    check_value("dm", 64'(dm), 64'd0);
    report_test("reset", errs_before);

    for (int p = 0; p < num_pkts && !timed_out; p++) begin
      gap = $urandom % 8;
      repeat (gap) @(posedge clk);
      wait_ack(1'b0, cycles);
      if (timed_out) break;
      @(posedge clk);
      clear_monitor();
      next_pkt.pid  = pid_e'(stim_mem[p*COLS][PID_W-1:0]);
      next_pkt.addr = stim_mem[p*COLS+1][ADDR_W-1:0];
      next_pkt.endp = stim_mem[p*COLS+2][ENDP_W-1:0];
      next_pkt.data = stim_mem[p*COLS+3];
      kind          = next_pkt.pid;
      errs_before   = err_cnt;
      req <= 1'b1;
      pkt <= next_pkt;
      wait_ack(1'b1, cycles);
      if (timed_out) break;
      check_packet(next_pkt, stim_mem[p*COLS+4]);
      @(posedge clk);
      req <= 1'b0;
      // the serializer sees req low on the next edge and drops ack there
      wait_ack(1'b0, cycles);
      if (timed_out) break;
      check_value("ack_fall_cycles", 64'(cycles), 64'd2);
      report_test(kind.name(), errs_before);
    end

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/usb_tx_stim.txt
// one packet per line: pid addr endp data expected_crc, all hex
// crc is the field value as sent LSB first, unused for ACK and NAK
E1 00 0 0000000000000000 02
C3 00 0 FFFFFFFFFFFFFFFF 70FE
D2 00 0 0000000000000000 0
69 15 E 0000000000000000 1D
C3 00 0 00000000000000FF F0F0
5A 00 0 0000000000000000 0
E1 7F F 0000000000000000 08
C3 00 0 0000000000000000 F4BF
69 00 0 0000000000000000 02

//--- usb_tx.f
logic/usb_tx_pkg.sv
logic/crc_gen.sv
logic/bit_stuffer.sv
logic/nrzi_encoder.sv
logic/line_driver.sv
logic/packet_serializer.sv
logic/usb_tx.sv
tb/tb_clock_gen.sv
tb/tb_usb_tx.sv
